/* Makefile */
VERILATOR  ?= verilator
TB_TOP     := loader_tb
RTL_TOP    := loader_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+verification
verilog/loader_pkg.sv
verilog/uart_rx.sv
verilog/word_loader.sv
verilog/prog_ram.sv
verilog/led_matrix_scan.sv
verilog/loader_top.sv
verification/loader_tb.sv

/* verification/loader_tb_util.svh */
// fibonacci lfsr with taps 32 22 2 1
function automatic logic next_random_bit();
  logic fb;
  fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
  lfsr = {lfsr[30:0], fb};
  return fb;
endfunction

function automatic logic [15:0] random_word();
  logic [15:0] w;
  int          i;
  for (i = 0; i < 16; i++) w = {w[14:0], next_random_bit()};
  return (w == END_WORD) ? 16'h0000 : w;  // marker stays out of the payload
endfunction

// expected loader state fed one received byte at a time
function automatic void model_byte(input logic [7:0] b);
  if (!exp_phase) begin
    exp_hi = b;
  end else begin
    exp_last = {exp_hi, b};
    exp_mem[exp_addr[ADDR_WIDTH-1:1]] = exp_last;
    have_word = 1'b1;
    exp_done  = (exp_last == END_WORD);
    exp_count = exp_done ? 8'd0 : exp_count + 8'd1;
    exp_addr  = exp_done ? LOAD_BASE : exp_addr + ADDR_WIDTH'(2);
  end
  exp_phase = ~exp_phase;
endfunction

// segments a..g in bits 7..1 and bit 4 of the value on the dot
function automatic logic [7:0] seven_seg_code(input logic [4:0] n);
  logic [7:0] code;
  int         s;
  code[0] = n[4];
  for (s = 0; s < 7; s++) code[7-s] = SEG_DIGITS[s][n[3:0]];
  return code;
endfunction

// 8N1 frame followed by one idle bit
task automatic send_frame(input logic [7:0] data, input logic stop);
  logic [9:0] bits;
  int         i;
  bits = {stop, data, 1'b0};
  for (i = 0; i < 10; i++) begin
    if (i == 9) settled = 1'b0;  // DUT may update from the stop bit on
    @(posedge sys_clk);
    uart_rxd <= bits[i];
    repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
  end
  @(posedge sys_clk);
  uart_rxd <= 1'b1;
  repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
  if (stop) model_byte(data);  // bad frame never reaches the loader
  settled = 1'b1;
endtask

task automatic send_word(input logic [15:0] w);
  send_frame(w[15:8], 1'b1);
  send_frame(w[7:0], 1'b1);
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("** Error: %s expected %h got %h", name, exp, got);
    $display("Regression failed");
    $fatal(1, "%s does not match the model", name);
  end
endtask

/* verification/loader_tb.sv */
`timescale 1ns/1ns

module loader_tb;
  import loader_pkg::*;

  localparam int N_FRAMES    = 39;  // 13 words, 5 words, one bad frame, 1 word
  localparam int CYCLE_LIMIT = N_FRAMES * 10 * CLKS_PER_BIT
                             + 4 * ROW_COUNT * SCAN_PERIOD + 2000;
  // hex digits lighting each segment from a to g
  localparam logic [0:6][15:0] SEG_DIGITS = {16'hd7ed, 16'h279f, 16'h2ffb, 16'h7b6d,
                                             16'hfd45, 16'hdff1, 16'hef7c};

  logic                  sys_clk;
  logic                  rst_n;
  logic                  uart_rxd;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  rd_en;
  logic [15:0]           rd_data;
  logic                  load_done;
  logic [7:0]            led_col;
  logic [ROW_COUNT-1:0]  led_row;

  logic [15:0]           exp_mem [0:RAM_DEPTH-1];
  logic [ADDR_WIDTH-1:0] exp_addr;
  logic [7:0]            exp_count;
  logic                  exp_done;
  logic                  exp_phase;
  logic [7:0]            exp_hi;
  logic [15:0]           exp_last;
  logic                  have_word;
  logic                  settled;   // model matches the DUT right now
  logic [31:0]           lfsr;
  logic [7:0]            bad_byte;
  int                    cycles = 0;
  int                    lit_run;
  int                    exp_row;

  `include "loader_tb_util.svh"

  loader_top dut_i (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .uart_rxd  (uart_rxd),
    .rd_addr   (rd_addr),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .load_done (load_done),
    .led_col   (led_col),
    .led_row   (led_row)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Regression failed");
      $fatal(1, "timeout, the test sequence did not finish in %0d cycles", CYCLE_LIMIT);
    end
  end

  task automatic readback(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge sys_clk);
      rd_addr <= LOAD_BASE + ADDR_WIDTH'(2 * i);
      rd_en   <= 1'b1;
      @(posedge sys_clk);
      rd_en <= 1'b0;
      @(negedge sys_clk);
      check("rd_data", rd_data, exp_mem[(LOAD_BASE >> 1) + i]);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    uart_rxd = 1'b1;
    rd_en = 1'b0;
    rd_addr = '0;
    lfsr = 32'ha9c1e6fc;
    settled = 1'b1;
    exp_addr = LOAD_BASE;
    exp_count = 8'd0;
    exp_done = 1'b0;
    exp_phase = 1'b0;
    have_word = 1'b0;
    repeat (3) @(posedge sys_clk);
    rst_n <= 1'b1;
    @(negedge sys_clk);
    check("led_row", led_row, 0);
    check("load_done", load_done, 0);
    wait (led_row[ROW_COUNT-1]);  // count row seen before any frame
    repeat (12) send_word(random_word());
    send_word(END_WORD);
    check("load_done", load_done, 1);
    readback(13);
    repeat ((ROW_COUNT + 1) * SCAN_PERIOD) @(posedge sys_clk);
    send_word(random_word());
    check("load_done", load_done, 0);  // falls after the first new word
    repeat (3) send_word(random_word());
    send_word(END_WORD);
    check("load_done", load_done, 1);
    readback(13);  // later words of the first program survive
    repeat ((ROW_COUNT + 1) * SCAN_PERIOD) @(posedge sys_clk);
    repeat (8) bad_byte = {bad_byte[6:0], next_random_bit()};
    send_frame(bad_byte, 1'b0);
    readback(13);
    repeat ((ROW_COUNT + 1) * SCAN_PERIOD) @(posedge sys_clk);
    send_word(random_word());  // a swallowed bad byte would shift the byte pairing
    readback(1);
    $display("Regression passed");
    $finish;
  end

  // scan order, stretch length and row contents
  initial begin
    lit_run = 0;
    exp_row = 0;
    forever begin
      @(negedge sys_clk);
      if (rst_n) begin
        check("led_row extra bits", 32'(led_row & (led_row - 1'b1)), 0);
        if (led_row != '0) begin
          if (lit_run == 0) check("led_row", 32'(led_row), 1 << exp_row);
          lit_run = lit_run + 1;
          if (settled) begin
            case (exp_row)
              0: if (have_word) check("led_col", 32'(led_col), 32'(exp_last[15:8]));
              1: if (have_word) check("led_col", 32'(led_col), 32'(exp_last[7:0]));
              2: check("led_col", 32'(led_col), 32'(seven_seg_code(exp_addr[4:0])));
              default: check("led_col", 32'(led_col), 32'(exp_count));
            endcase
          end
        end else if (lit_run != 0) begin
          check("lit stretch length", lit_run, SCAN_PERIOD - GAP_ON - GAP_OFF);
          lit_run = 0;
          exp_row = (exp_row + 1) % ROW_COUNT;
        end
        if (settled) check("load_done", 32'(load_done), 32'(exp_done));
      end
    end
  end

endmodule

/* verilog/led_matrix_scan.sv */
`timescale 1ns/1ns

module led_matrix_scan (
  input  logic                             sys_clk,
  input  logic                             rst_n,
  input  loader_pkg::wr_req_s              wr_req,
  input  loader_pkg::load_status_s         status,
  output logic [7:0]                       led_col,
  output logic [loader_pkg::ROW_COUNT-1:0] led_row
);
  import loader_pkg::*;

  ram_word_u             last_word;
  logic [SCAN_CNT_W-1:0] scan_cnt;
  logic [ROW_W-1:0]      row_idx;
  logic                  lit;

  // seven-segment code, segments in 7..1 and n[4] on the dot
  function automatic logic [7:0] encode_7seg(input logic [4:0] n);
    logic [6:0] seg;
    case (n[3:0])
      4'h0: seg = 7'b1111110;
      4'h1: seg = 7'b0110000;
      4'h2: seg = 7'b1101101;
      4'h3: seg = 7'b1111001;
      4'h4: seg = 7'b0110011;
      4'h5: seg = 7'b1011011;
      4'h6: seg = 7'b1011111;
      4'h7: seg = 7'b1110010;
      4'h8: seg = 7'b1111111;
      4'h9: seg = 7'b1111011;
      4'ha: seg = 7'b1110111;
      4'hb: seg = 7'b0011111;
      4'hc: seg = 7'b1001110;
      4'hd: seg = 7'b0111101;
      4'he: seg = 7'b1001111;
      default: seg = 7'b1000111;  // f
    endcase
    return {seg, n[4]};
  endfunction

  always_ff @(posedge sys_clk) begin
    if (wr_req.we) last_word <= wr_req.data;
  end

  // one row period per counter lap
  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      scan_cnt <= '0;
      row_idx  <= '0;
    end else if (scan_cnt == SCAN_LAST) begin
      scan_cnt <= '0;
      if (row_idx == ROW_W'(ROW_COUNT - 1)) begin
        row_idx <= '0;
      end else begin
        row_idx <= row_idx + 1'b1;
      end
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  // dark at both ends of the period so rows do not ghost
  assign lit     = (scan_cnt >= LIT_FIRST) && (scan_cnt < LIT_END);
  assign led_row = lit ? (ROW_COUNT'(1) << row_idx) : '0;

  always_comb begin
    case (row_idx)
      2'd0:    led_col = last_word.bytes.hi;
      2'd1:    led_col = last_word.bytes.lo;
      2'd2:    led_col = encode_7seg(status.addr[4:0]);
      default: led_col = status.word_count;  // words loaded so far
    endcase
  end

endmodule

/* verilog/loader_pkg.sv */
package loader_pkg;

  // uart timing, kept short for simulation
  localparam int CLKS_PER_BIT = 8;
  localparam int CYC_CNT_W    = $clog2(CLKS_PER_BIT);
  localparam logic [CYC_CNT_W-1:0] CYC_MID  = CYC_CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CYC_CNT_W-1:0] CYC_LAST = CYC_CNT_W'(CLKS_PER_BIT - 1);

  // program memory
  localparam int ADDR_WIDTH = 11;                 // byte address
  localparam int RAM_DEPTH  = 2 ** (ADDR_WIDTH - 1);
  localparam logic [ADDR_WIDTH-1:0] LOAD_BASE = ADDR_WIDTH'('h200);
  localparam logic [15:0] END_WORD = 16'hffff;   // end of program marker

  // led matrix scan
  localparam int SCAN_PERIOD = 64;
  localparam int GAP_ON      = 4;
  localparam int GAP_OFF     = 8;
  localparam int ROW_COUNT   = 4;
  localparam int SCAN_CNT_W  = $clog2(SCAN_PERIOD);
  localparam int ROW_W       = $clog2(ROW_COUNT);
  localparam logic [SCAN_CNT_W-1:0] SCAN_LAST = SCAN_CNT_W'(SCAN_PERIOD - 1);
  localparam logic [SCAN_CNT_W-1:0] LIT_FIRST = SCAN_CNT_W'(GAP_ON);
  localparam logic [SCAN_CNT_W-1:0] LIT_END   = SCAN_CNT_W'(SCAN_PERIOD - GAP_OFF);

  typedef struct packed {
    logic       valid;  // one cycle per received frame
    logic [7:0] data;
  } rx_byte_s;

  // memory sees a word, the display sees two bytes
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
  } ram_word_u;

  typedef struct packed {
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    ram_word_u             data;
  } wr_req_s;

  typedef struct packed {
    logic                  load_done;
    logic [ADDR_WIDTH-1:0] addr;        // next byte address to be written
    logic [7:0]            word_count;
  } load_status_s;

endpackage

/* verilog/loader_top.sv */
`timescale 1ns/1ns

module loader_top (
  input  logic                              sys_clk,
  input  logic                              rst_n,
  input  logic                              uart_rxd,
  input  logic [loader_pkg::ADDR_WIDTH-1:0] rd_addr,
  input  logic                              rd_en,
  output logic [15:0]                       rd_data,
  output logic                              load_done,
  output logic [7:0]                        led_col,
  output logic [loader_pkg::ROW_COUNT-1:0]  led_row
);
  import loader_pkg::*;

  rx_byte_s     rx_byte;
  wr_req_s      wr_req;
  load_status_s status;

  uart_rx uart_rx_i (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .rxd     (uart_rxd),
    .rx_byte (rx_byte)
  );

  word_loader word_loader_i (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .rx_byte (rx_byte),
    .wr_req  (wr_req),
    .status  (status)
  );

  // readback port stands in for the core's read side
  prog_ram prog_ram_i (
    .sys_clk (sys_clk),
    .wr_req  (wr_req),
    .rd_addr (rd_addr),
    .rd_en   (rd_en),
    .rd_data (rd_data)
  );

  led_matrix_scan led_matrix_scan_i (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .wr_req  (wr_req),
    .status  (status),
    .led_col (led_col),
    .led_row (led_row)
  );

  assign load_done = status.load_done;

endmodule

/* verilog/prog_ram.sv */
`timescale 1ns/1ns

module prog_ram (
  input  logic                              sys_clk,
  input  loader_pkg::wr_req_s               wr_req,
  input  logic [loader_pkg::ADDR_WIDTH-1:0] rd_addr,
  input  logic                              rd_en,
  output logic [15:0]                       rd_data
);
  import loader_pkg::*;

  logic [15:0]           mem [0:RAM_DEPTH-1];
  logic [ADDR_WIDTH-2:0] wr_idx;
  logic [ADDR_WIDTH-2:0] rd_idx;

  // word index, byte address bit 0 dropped
  assign wr_idx = wr_req.addr[ADDR_WIDTH-1:1];
  assign rd_idx = rd_addr[ADDR_WIDTH-1:1];

  always_ff @(posedge sys_clk) begin
    if (wr_req.we) mem[wr_idx] <= wr_req.data.word;
  end

  // read before write on the same address
  always_ff @(posedge sys_clk) begin
    if (rd_en) rd_data <= mem[rd_idx];
  end

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  logic                 rxd,
  output loader_pkg::rx_byte_s rx_byte
);
  import loader_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} rx_state_e;

  rx_state_e            state;
  logic                 rxd_meta;
  logic                 rxd_sync;
  logic                 rxd_prev;   // for start edge detect
  logic [CYC_CNT_W-1:0] cyc_cnt;
  logic [2:0]           bit_cnt;
  logic [7:0]           shift_q;
  logic                 valid_q;

  // line idles high
  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      cyc_cnt <= '0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          cyc_cnt <= '0;
          bit_cnt <= '0;
          if (rxd_prev && !rxd_sync) state <= ST_START;  // falling edge
        end
        ST_START: begin
          if (cyc_cnt == CYC_MID) begin
            cyc_cnt <= '0;
            state   <= rxd_sync ? ST_IDLE : ST_DATA;     // high at mid-bit is a glitch
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        ST_DATA: begin
          if (cyc_cnt == CYC_LAST) begin
            cyc_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= ST_STOP;
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        ST_STOP: begin
          if (cyc_cnt == CYC_LAST) begin
            valid_q <= rxd_sync;  // framing error drops the byte
            state   <= ST_IDLE;
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge sys_clk) begin
    if (state == ST_DATA && cyc_cnt == CYC_LAST) shift_q <= {rxd_sync, shift_q[7:1]};
  end

  assign rx_byte.valid = valid_q;
  assign rx_byte.data  = shift_q;

endmodule

/* verilog/word_loader.sv */
`timescale 1ns/1ns

module word_loader (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  loader_pkg::rx_byte_s     rx_byte,
  output loader_pkg::wr_req_s      wr_req,
  output loader_pkg::load_status_s status
);
  import loader_pkg::*;

  logic                  phase;     // 0 while the high byte is expected
  ram_word_u             word_q;    // last two bytes, high byte first
  logic                  we_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [7:0]            count_q;
  logic                  done_q;
  logic                  end_hit;

  // word being written is the end marker
  assign end_hit = (word_q.word == END_WORD);

  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      phase <= 1'b0;
    end else if (rx_byte.valid) begin
      phase <= ~phase;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_byte.valid) word_q.word <= {word_q.bytes.lo, rx_byte.data};
  end

  // one write per byte pair, a cycle after the low byte
  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else begin
      we_q <= rx_byte.valid & phase;
    end
  end

  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= LOAD_BASE;
    end else if (we_q) begin
      addr_q <= end_hit ? LOAD_BASE : addr_q + ADDR_WIDTH'(2);
    end
  end

  // load_done stays up until the next ordinary word
  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (we_q) begin
      done_q <= end_hit;
    end
  end

  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (we_q) begin
      count_q <= end_hit ? 8'd0 : count_q + 8'd1;  // cleared as load_done rises
    end
  end

  assign wr_req.we   = we_q;
  assign wr_req.addr = addr_q;
  assign wr_req.data = word_q;

  assign status.load_done  = done_q;
  assign status.addr       = addr_q;
  assign status.word_count = count_q;

endmodule
